// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = tb_xbit_top
FLIST = project.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with $(TOOL), run $(TOP) and check $(LOG)"
	@echo "make clean  remove $(BUILD) and $(LOG)"
	@echo "make help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: hw/xbit_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module xbit_ctrl import xbit_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  logic [ADR_W-1:0]  wb_adr,
  input  logic [31:0]       wb_dat_w,
  input  logic [3:0]        wb_sel, // Byte lanes ignored, every access is a full word.
  output logic [31:0]       wb_dat_r,
  output logic              wb_ack,
  xbit_if.ctrl              bus,
  input  logic              sweep_busy,
  input  logic [ROW_AW-1:0] sweep_row,
  output logic              sweep_start
);

  typedef enum logic [2:0] {IDLE, RD_WAIT, RD_DATA, MERGE, ACK} state_e;

  state_e state;
  state_e state_n;
  sel_e   sel;
  logic   req;
  logic   stat_wr;
  logic   perr_sticky;

  assign req = wb_cyc && wb_stb;
  assign sel = sel_e'(wb_adr[ADR_W-1 -: 2]);
  assign stat_wr = (state == IDLE) && req && (sel == SEL_STAT) && wb_we;
  assign sweep_start = stat_wr && wb_dat_w[0] && !sweep_busy;

  always_comb begin
    state_n = state;
    case (state)
      IDLE: begin
        if (req) begin
          if (sel == SEL_STAT) state_n = ACK;
          else if (!sweep_busy) begin // Row traffic waits for the sweep.
            if (sel == SEL_SLOT) state_n = RD_WAIT;
            else if (wb_we) state_n = MERGE;
            else state_n = ACK;
          end
        end
      end
      RD_WAIT: state_n = RD_DATA;
      RD_DATA: state_n = wb_we ? MERGE : ACK;
      MERGE:   state_n = ACK;
      default: state_n = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= IDLE;
      wb_ack      <= 1'b0;
      perr_sticky <= 1'b0;
    end else begin
      state  <= state_n;
      wb_ack <= (state_n == ACK);
      if (state == RD_DATA && bus.perr) perr_sticky <= 1'b1;
      else if (stat_wr && wb_dat_w[1]) perr_sticky <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE) begin
      wb_dat_r <= (sel == SEL_STAT) ? {30'd0, perr_sticky, sweep_busy} : 32'd0;
    end else if (state == RD_DATA) begin
      wb_dat_r <= {30'd0, bus.pair};
    end
  end

  always_comb begin
    bus.rd_en    = 1'b0;
    bus.wr_en    = 1'b0;
    bus.row      = wb_adr[SLOT_AW +: ROW_AW];
    bus.slot     = wb_adr[SLOT_AW-1:0];
    bus.op       = OP_NONE;
    bus.pbit     = wb_dat_w[1:0];
    bus.d128     = wb_dat_w[2];
    bus.ins_data = wb_dat_w;
    if (sweep_busy) begin
      bus.wr_en = 1'b1;
      bus.row   = sweep_row;
      bus.op    = OP_CLEAR;
    end
    case (state)
      RD_WAIT: begin
        bus.rd_en = 1'b1;
        bus.op    = wb_we ? OP_MERGE : OP_NONE;
      end
      MERGE: begin
        bus.wr_en = 1'b1;
        case (sel)
          SEL_ROW:  bus.op = OP_INSERT;
          SEL_DIAG: bus.op = OP_INSERT_BAD;
          default:  bus.op = OP_MERGE;
        endcase
      end
      default: ;
    endcase
  end

  a_ack_pulse: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack);

  a_wr_has_op: assert property (
    @(posedge clk) disable iff (rst)
    bus.wr_en |-> bus.op != OP_NONE
  );

endmodule

`default_nettype wire

// File: hw/xbit_if.sv
`timescale 1ns/1ps
`default_nettype none

interface xbit_if import xbit_pkg::*;;

  logic               rd_en;
  logic               wr_en;
  logic [ROW_AW-1:0]  row;
  logic [SLOT_AW-1:0] slot;
  op_e                op;
  logic [1:0]         pbit;   // Markers to write, bit 1 only with d128.
  logic               d128;
  row_t               ins_data;
  logic [1:0]         pair;   // Valid the cycle after rd_en.
  logic               perr;

  modport ctrl (
    output rd_en, wr_en, row, slot, op, pbit, d128, ins_data,
    input  pair, perr
  );

  modport dp (
    input  rd_en, wr_en, row, slot, op, pbit, d128, ins_data,
    output pair, perr
  );

endinterface

`default_nettype wire

// File: hw/xbit_pkg.sv
`default_nettype none

package xbit_pkg;

  localparam int ROW_AW = 5;
  localparam int ROWS = 32;
  localparam int SLOT_AW = 5;
  localparam int ROW_W = 32;
  localparam int BYTES = ROW_W / 8;
  localparam int CODED_W = ROW_W + BYTES;
  localparam int PAR0_BIT = 8; // Parity of byte 0.
  localparam int ADR_W = 2 + ROW_AW + SLOT_AW;

  typedef logic [ROW_W-1:0] row_t;
  typedef logic [CODED_W-1:0] coded_row_t; // {p3,b3,p2,b2,p1,b1,p0,b0}.

  typedef enum logic [1:0] {
    SEL_SLOT = 2'd0,
    SEL_ROW  = 2'd1,
    SEL_STAT = 2'd2,
    SEL_DIAG = 2'd3
  } sel_e;

  typedef enum logic [2:0] {
    OP_NONE,
    OP_MERGE,
    OP_INSERT,
    OP_INSERT_BAD,
    OP_CLEAR
  } op_e;

  // Even parity per byte.
  function automatic coded_row_t row_encode(row_t d);
    coded_row_t c;
    for (int b = 0; b < BYTES; b++) begin
      c[9*b +: 9] = {^d[8*b +: 8], d[8*b +: 8]};
    end
    return c;
  endfunction

  function automatic row_t row_decode(coded_row_t c);
    row_t d;
    for (int b = 0; b < BYTES; b++) begin
      d[8*b +: 8] = c[9*b +: 8];
    end
    return d;
  endfunction

  function automatic logic row_parity_ok(coded_row_t c);
    logic ok;
    ok = 1'b1;
    for (int b = 0; b < BYTES; b++) begin
      if (^c[9*b +: 9]) ok = 1'b0;
    end
    return ok;
  endfunction

endpackage

`default_nettype wire

// File: hw/xbit_ram.sv
`timescale 1ns/1ps
`default_nettype none

module xbit_ram import xbit_pkg::*; (
  input  logic              clk,
  input  logic [ROW_AW-1:0] rd_addr,
  output coded_row_t        rd_data,
  input  logic              wr_en,
  input  logic [ROW_AW-1:0] wr_addr,
  input  coded_row_t        wr_data
);

  coded_row_t        mem [ROWS];
  logic [ROW_AW-1:0] rd_addr_q;
  coded_row_t        old_row;
  logic              use_old;

  always_ff @(posedge clk) begin
    rd_addr_q <= rd_addr;
    // Read and write of one row in the same cycle see the row before the write.
    use_old <= wr_en && (wr_addr == rd_addr);
    old_row <= mem[rd_addr];
    if (wr_en) mem[wr_addr] <= wr_data;
  end

  assign rd_data = use_old ? old_row : mem[rd_addr_q];

endmodule

`default_nettype wire

// File: hw/xbit_rmw.sv
`timescale 1ns/1ps
`default_nettype none

module xbit_rmw import xbit_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  xbit_if.dp                bus,
  output logic [ROW_AW-1:0] ram_rd_addr,
  input  coded_row_t        ram_rd_data,
  output logic              ram_wr_en,
  output logic [ROW_AW-1:0] ram_wr_addr,
  output coded_row_t        ram_wr_data
);

  logic [ROW_AW-1:0]  rd_row_q;
  logic [SLOT_AW-1:0] rd_slot_q;
  op_e                rd_op_q;
  logic [1:0]         rd_pbit_q;
  logic               rd_d128_q;
  logic [SLOT_AW-1:0] next_slot;
  logic               last_slot;
  row_t               rd_row;
  row_t               merged;
  coded_row_t         ins_coded;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_op_q <= OP_NONE;
    end else if (bus.rd_en) begin
      rd_op_q <= bus.op;
    end
  end

  // Access fields kept so the merge lines up with the returning row.
  always_ff @(posedge clk) begin
    if (bus.rd_en) begin
      rd_row_q  <= bus.row;
      rd_slot_q <= bus.slot;
      rd_pbit_q <= bus.pbit;
      rd_d128_q <= bus.d128;
    end
  end

  assign ram_rd_addr = bus.rd_en ? bus.row : rd_row_q; // Hold the row until the merge.
  assign rd_row = row_decode(ram_rd_data);
  assign next_slot = rd_slot_q + 1'b1;
  assign last_slot = (rd_slot_q == '1);

  // A pair never wraps into the next row.
  assign bus.pair = {last_slot ? 1'b0 : rd_row[next_slot], rd_row[rd_slot_q]};
  assign bus.perr = !row_parity_ok(ram_rd_data);

  always_comb begin
    merged = rd_row;
    merged[rd_slot_q] = rd_pbit_q[0];
    if (rd_d128_q && !last_slot) merged[next_slot] = rd_pbit_q[1];
  end

  always_comb begin
    ins_coded = row_encode(bus.ins_data);
    case (bus.op)
      OP_MERGE:  ram_wr_data = row_encode(merged);
      OP_INSERT: ram_wr_data = ins_coded;
      OP_INSERT_BAD: begin
        ram_wr_data = ins_coded;
        ram_wr_data[PAR0_BIT] = ~ins_coded[PAR0_BIT]; // Diagnostic fault.
      end
      default:   ram_wr_data = '0; // Zero row has zero parity.
    endcase
  end

  assign ram_wr_en = bus.wr_en;
  assign ram_wr_addr = (bus.op == OP_MERGE) ? rd_row_q : bus.row;

  a_merge_after_read: assert property (
    @(posedge clk) disable iff (rst)
    bus.wr_en && bus.op == OP_MERGE |->
      $past(bus.rd_en, 2) && rd_op_q == OP_MERGE && bus.row == rd_row_q
  );

endmodule

`default_nettype wire

// File: hw/xbit_sweep.sv
`timescale 1ns/1ps
`default_nettype none

module xbit_sweep import xbit_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  output logic              busy,
  output logic [ROW_AW-1:0] row
);

  always_ff @(posedge clk) begin
    if (rst || start) begin
      busy <= 1'b1; // Sweep runs straight out of reset.
      row  <= '0;
    end else if (busy) begin
      row <= row + 1'b1;
      if (row == ROW_AW'(ROWS - 1)) begin
        busy <= 1'b0;
      end
    end
  end

  // The controller drops a start that arrives mid-sweep.
  a_no_restart: assert property (
    @(posedge clk) disable iff (rst)
    start |-> !busy
  );

endmodule

`default_nettype wire

// File: hw/xbit_top.sv
`timescale 1ns/1ps
`default_nettype none

module xbit_top import xbit_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic             wb_cyc,
  input  logic             wb_stb,
  input  logic             wb_we,
  input  logic [ADR_W-1:0] wb_adr,
  input  logic [31:0]      wb_dat_w,
  input  logic [3:0]       wb_sel,
  output logic [31:0]      wb_dat_r,
  output logic             wb_ack
);

  logic              sweep_start;
  logic              sweep_busy;
  logic [ROW_AW-1:0] sweep_row;
  logic [ROW_AW-1:0] ram_rd_addr;
  coded_row_t        ram_rd_data;
  logic              ram_wr_en;
  logic [ROW_AW-1:0] ram_wr_addr;
  coded_row_t        ram_wr_data;

  xbit_if u_bus ();

  xbit_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_sel      (wb_sel),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .bus         (u_bus.ctrl),
    .sweep_busy  (sweep_busy),
    .sweep_row   (sweep_row),
    .sweep_start (sweep_start)
  );

  xbit_sweep u_sweep (
    .clk   (clk),
    .rst   (rst),
    .start (sweep_start),
    .busy  (sweep_busy),
    .row   (sweep_row)
  );

  xbit_rmw u_rmw (
    .clk         (clk),
    .rst         (rst),
    .bus         (u_bus.dp),
    .ram_rd_addr (ram_rd_addr),
    .ram_rd_data (ram_rd_data),
    .ram_wr_en   (ram_wr_en),
    .ram_wr_addr (ram_wr_addr),
    .ram_wr_data (ram_wr_data)
  );

  xbit_ram u_ram (
    .clk     (clk),
    .rd_addr (ram_rd_addr),
    .rd_data (ram_rd_data),
    .wr_en   (ram_wr_en),
    .wr_addr (ram_wr_addr),
    .wr_data (ram_wr_data)
  );

endmodule

`default_nettype wire

// File: project.f
hw/xbit_pkg.sv
hw/xbit_if.sv
hw/xbit_ram.sv
hw/xbit_rmw.sv
hw/xbit_sweep.sv
hw/xbit_ctrl.sv
hw/xbit_top.sv
sim/tb_xbit_top.sv

// File: sim/tb_xbit_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_xbit_top import xbit_pkg::*; ();

  localparam int CLK_PERIOD = 20;
  localparam int ACK_LIMIT = 100;
  localparam int N_RANDOM = 300;
  localparam int WATCHDOG_NS = 400 * 40 * CLK_PERIOD; // Operations times cycles each.

  logic             clk = 1'b0;
  logic             rst;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  logic [ADR_W-1:0] wb_adr;
  logic [31:0]      wb_dat_w;
  logic [3:0]       wb_sel;
  logic [31:0]      wb_dat_r;
  logic             wb_ack;

  logic [31:0] lfsr_state;
  row_t        model_row [ROWS];
  logic        model_bad [ROWS]; // Row was written with a parity fault.
  logic        model_sticky;
  int          errors;
  int          n_access;
  int          n_ack = 0;

  xbit_top u_xbit_top (
    .clk (clk), .rst (rst),
    .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we),
    .wb_adr (wb_adr), .wb_dat_w (wb_dat_w), .wb_sel (wb_sel),
    .wb_dat_r (wb_dat_r), .wb_ack (wb_ack)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(negedge clk) begin
    if (!rst && wb_ack) n_ack++;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0t, the run did not finish", $time);
    $display("Simulation failed");
    $finish;
  end

  // Galois form of x^32 + x^31 + x^29 + x + 1.
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] act);
    $display("FAIL at %0t: %s expected %h, got %h", $time, name, exp, act);
    errors++;
  endtask

  task automatic clear_model();
    for (int r = 0; r < ROWS; r++) begin
      model_row[r] = '0;
      model_bad[r] = 1'b0;
    end
  endtask

  // Holds the request until ack, then releases the bus for one cycle.
  task automatic wb_access(logic we, logic [ADR_W-1:0] adr, logic [31:0] dat,
                           output logic [31:0] rdata, output int cycles);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = dat;
    wb_sel = 4'hf;
    n_access++;
    cycles = 0;
    while (wb_ack !== 1'b1 && cycles < ACK_LIMIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    rdata = wb_dat_r;
    if (wb_ack !== 1'b1) begin
      $display("No ack within %0d cycles for address %h at %0t", ACK_LIMIT, adr, $time);
      errors++;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic write_slot(logic [ROW_AW-1:0] row, logic [SLOT_AW-1:0] slot, logic [2:0] bits);
    logic [31:0] rdata;
    int cycles;
    wb_access(1'b1, {SEL_SLOT, row, slot}, {29'd0, bits}, rdata, cycles);
    if (model_bad[row]) model_sticky = 1'b1; // The merge read checks parity too.
    model_row[row][slot] = bits[0];
    if (bits[2] && slot != '1) model_row[row][slot + 1'b1] = bits[1];
    model_bad[row] = 1'b0;
  endtask

  task automatic read_slot(logic [ROW_AW-1:0] row, logic [SLOT_AW-1:0] slot);
    logic [31:0] rdata;
    logic [31:0] exp;
    int cycles;
    exp = {30'd0, (slot == '1) ? 1'b0 : model_row[row][slot + 1'b1], model_row[row][slot]};
    wb_access(1'b0, {SEL_SLOT, row, slot}, 32'd0, rdata, cycles);
    if (model_bad[row]) model_sticky = 1'b1;
    if (rdata !== exp) begin
      report_mismatch($sformatf("wb_dat_r (row %0d slot %0d)", row, slot), exp, rdata);
    end
  endtask

  task automatic insert_row(logic [ROW_AW-1:0] row, row_t data, logic bad);
    logic [31:0] rdata;
    int cycles;
    sel_e sel;
    sel = bad ? SEL_DIAG : SEL_ROW;
    wb_access(1'b1, {sel, row, 5'd0}, data, rdata, cycles);
    model_row[row] = data;
    model_bad[row] = bad;
  endtask

  task automatic status_access(logic we, logic [1:0] cmd, output logic [31:0] rdata);
    int cycles;
    wb_access(we, {SEL_STAT, 10'd0}, {30'd0, cmd}, rdata, cycles);
    if (cycles != 1) begin
      $display("Status access at %0t acked after %0d cycles instead of 1", $time, cycles);
      errors++;
    end
  endtask

  task automatic expect_status(logic busy);
    logic [31:0] stat;
    logic [31:0] exp;
    exp = {30'd0, model_sticky, busy};
    status_access(1'b0, 2'b00, stat);
    if (stat !== exp) report_mismatch("wb_dat_r (status)", exp, stat);
  endtask

  task automatic write_status(logic [1:0] cmd);
    logic [31:0] rdata;
    status_access(1'b1, cmd, rdata);
    if (cmd[1]) model_sticky = 1'b0;
    if (cmd[0]) clear_model();
  endtask

  // Even slots reach every marker through the pair.
  task automatic check_all_rows();
    for (int r = 0; r < ROWS; r++) begin
      for (int s = 0; s < ROW_W; s += 2) begin
        read_slot(ROW_AW'(r), SLOT_AW'(s));
      end
    end
  endtask

  initial begin
    logic [31:0]        stat;
    logic [3:0]         kind;
    logic [ROW_AW-1:0]  row;
    logic [SLOT_AW-1:0] slot;
    int                 polls;
    rst = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    wb_sel = '0;
    lfsr_state = 32'd82;
    errors = 0;
    n_access = 0;
    model_sticky = 1'b0;
    clear_model(); // Reset starts a sweep.
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    if (wb_ack !== 1'b0) report_mismatch("wb_ack", 32'd0, {31'd0, wb_ack});
    expect_status(1'b1);
    stat = 32'd1;
    polls = 0;
    while (stat[0] === 1'b1 && polls < 2 * ROWS) begin
      status_access(1'b0, 2'b00, stat);
      polls++;
    end
    if (stat !== 32'd0) report_mismatch("wb_dat_r (status after sweep)", 32'd0, stat);
    check_all_rows();

    write_slot(5'd3, 5'd31, 3'b111); // Second marker falls off the row end.
    read_slot(5'd3, 5'd30);
    read_slot(5'd3, 5'd31);
    read_slot(5'd4, 5'd0);

    for (int i = 0; i < N_RANDOM; i++) begin
      kind = 4'(take_bits(4));
      row = ROW_AW'(take_bits(ROW_AW));
      slot = SLOT_AW'(take_bits(SLOT_AW));
      if (kind < 4'd6) begin
        write_slot(row, slot, 3'(take_bits(3)));
        read_slot(row, slot);
      end else if (kind < 4'd9) begin
        read_slot(row, slot);
      end else if (kind < 4'd12) begin
        insert_row(row, take_bits(ROW_W), 1'b0);
        read_slot(row, slot);
      end else if (kind == 4'd12) begin
        insert_row(row, take_bits(ROW_W), 1'b1);
      end else if (kind < 4'd15) begin
        expect_status(1'b0);
      end else begin
        write_status(2'b10);
      end
    end

    write_status(2'b10);
    insert_row(5'd9, 32'hA5C3_0F96, 1'b1);
    expect_status(1'b0);
    read_slot(5'd9, 5'd4);
    status_access(1'b0, 2'b00, stat);
    if (stat !== 32'd2) report_mismatch("wb_dat_r (status after fault)", 32'd2, stat);
    write_status(2'b10);
    expect_status(1'b0);
    insert_row(5'd9, 32'h0F0F_3C3C, 1'b0);
    read_slot(5'd9, 5'd4);
    expect_status(1'b0);

    // Slot read issued mid-sweep waits for the clear.
    insert_row(5'd17, 32'hFFFF_FFFF, 1'b0);
    write_status(2'b01);
    expect_status(1'b1);
    read_slot(5'd17, 5'd6);
    expect_status(1'b0);
    check_all_rows();

    if (n_ack != n_access) begin
      $display("Saw %0d acks for %0d accesses", n_ack, n_access);
      errors++;
    end
    $display("Errors: %0d, accesses: %0d, acks: %0d", errors, n_access, n_ack);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
